// File: sources.f
common/axi_wr_pkg.sv
hw/axi_wr_arbiter.sv
axi_write_router/axi_write_router.sv
hw/axi_wr_ram.sv
hw/axi_wr_regs.sv
hw/axi_wr_top.sv
tb/tb_axi_wr_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator and run it; a failing run exits non-zero
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module tb_axi_wr_top -f sources.f -o tb_axi_wr_top
./obj_dir/tb_axi_wr_top

// File: tb/tb_axi_wr_top.sv
// Random-stimulus testbench for the AXI write interconnect. Drives the CPU and
// DMA hosts with INCR bursts and checks B, the RAM words and the ctrl outputs.
module tb_axi_wr_top
    import axi_wr_pkg::*;
();

    localparam int wait_limit = 300;

    logic clk;
    logic rst_n;
    // Host signals indexed by host, 0 is the CPU and 1 the DMA
    logic [1:0]                awvalid, awready, wvalid, wready, wlast, bvalid, bready;
    logic [addr_width-1:0]     awaddr [2];
    logic [7:0]                awlen [2];
    logic [2:0]                awsize [2];
    logic [1:0]                awburst [2];
    logic [1:0]                bresp [2];
    logic [id_width-1:0]       awid [2];
    logic [id_width-1:0]       bid [2];
    logic [data_width-1:0]     wdata [2];
    logic [strb_width-1:0]     wstrb [2];
    logic [ram_addr_width-1:0] ram_rd_addr;
    logic [data_width-1:0]     ram_rd_data, ctrl0, ctrl1, ctrl2, ctrl3;

    // Reference model
    logic [data_width-1:0] ram_model [ram_words];
    logic [data_width-1:0] reg_model [4];
    int seed = 32'h5d0b;

    axi_wr_top i_dut (
        .clk (clk), .rst_n (rst_n),
        .cpu_awvalid (awvalid[0]), .cpu_awready (awready[0]), .cpu_awaddr (awaddr[0]),
        .cpu_awlen (awlen[0]), .cpu_awsize (awsize[0]), .cpu_awburst (awburst[0]),
        .cpu_awid (awid[0]), .cpu_wvalid (wvalid[0]), .cpu_wready (wready[0]),
        .cpu_wdata (wdata[0]), .cpu_wstrb (wstrb[0]), .cpu_wlast (wlast[0]),
        .cpu_bvalid (bvalid[0]), .cpu_bready (bready[0]), .cpu_bresp (bresp[0]),
        .cpu_bid (bid[0]),
        .dma_awvalid (awvalid[1]), .dma_awready (awready[1]), .dma_awaddr (awaddr[1]),
        .dma_awlen (awlen[1]), .dma_awsize (awsize[1]), .dma_awburst (awburst[1]),
        .dma_awid (awid[1]), .dma_wvalid (wvalid[1]), .dma_wready (wready[1]),
        .dma_wdata (wdata[1]), .dma_wstrb (wstrb[1]), .dma_wlast (wlast[1]),
        .dma_bvalid (bvalid[1]), .dma_bready (bready[1]), .dma_bresp (bresp[1]),
        .dma_bid (bid[1]),
        .ram_rd_addr (ram_rd_addr), .ram_rd_data (ram_rd_data),
        .ctrl0 (ctrl0), .ctrl1 (ctrl1), .ctrl2 (ctrl2), .ctrl3 (ctrl3)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////
    task automatic stop_with_error(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            stop_with_error($sformatf("MISMATCH %s expected %h actual %h",
                                      name, expected, actual));
        end
    endtask

    function automatic logic [31:0] rand32();
        return $random(seed);
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'(rand32() % 32'(hi - lo + 1));
    endfunction

    function automatic logic [data_width-1:0] merge_bytes(
            input logic [data_width-1:0] old_word, input logic [data_width-1:0] new_word,
            input logic [strb_width-1:0] strb);
        logic [data_width-1:0] result;
        result = old_word;
        for (int b = 0; b < strb_width; b++) begin
            if (strb[b]) begin
                result[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return result;
    endfunction

    // 0 for the RAM, 1 for the registers, 2 for a miss
    function automatic int region_of(input logic [addr_width-1:0] a);
        if (a < ram_end) begin
            return 0;
        end
        if (a >= reg_base && a < reg_end) begin
            return 1;
        end
        return 2;
    endfunction

    function automatic logic level_of(input int kind, input bit h);
        case (kind)
            0: return awready[h];
            1: return wready[h];
            default: return bvalid[h];
        endcase
    endfunction

    // Samples on the falling edge, the transfer then happens on the next rising edge
    task automatic wait_for(input int kind, input bit h, input string what);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!level_of(kind, h)) begin
            if (cycles == wait_limit) begin
                stop_with_error($sformatf("Timed out waiting for %s on host %0d", what, h));
            end else begin
                cycles++;
                @(negedge clk);
            end
        end
    endtask

    // One INCR burst on host h, fill writes an address pattern with all strobes
    task automatic write_burst(input string name, input bit h,
                               input logic [addr_width-1:0] addr, input int beats,
                               input int hold, input bit fill);
        int                    region;
        int                    w;
        logic [addr_width-1:0] a_beat;
        logic [data_width-1:0] data;
        logic [strb_width-1:0] strb;
        logic [id_width-1:0]   id;
        logic [1:0]            resp0;
        logic [id_width-1:0]   id0;
        region = region_of(addr);
        // Top ID bit names the host so crossed B responses show up
        id = {h, (id_width-1)'(rand32())};
        @(posedge clk);
        awvalid[h] <= 1'b1;
        awaddr[h]  <= addr;
        awlen[h]   <= 8'(beats - 1);
        awid[h]    <= id;
        wait_for(0, h, "awready");
        for (int i = 0; i < beats; i++) begin
            a_beat = addr + 16'(4 * i);
            data = fill ? {a_beat, ~a_beat} : rand32();
            strb = fill ? 4'hf : strb_width'(rand32());
            @(posedge clk);
            awvalid[h] <= 1'b0;
            wvalid[h]  <= 1'b1;
            wdata[h]   <= data;
            wstrb[h]   <= strb;
            wlast[h]   <= (i == beats - 1);
            // Word offset from the region base, stepping one word per beat
            if (region == 0) begin
                w = (int'(addr - ram_base) / 4 + i) % ram_words;
                ram_model[w] = merge_bytes(ram_model[w], data, strb);
            end else if (region == 1) begin
                w = (int'(addr - reg_base) / 4 + i) % 4;
                reg_model[w] = merge_bytes(reg_model[w], data, strb);
            end
            wait_for(1, h, "wready");
        end
        @(posedge clk);
        wvalid[h] <= 1'b0;
        wlast[h]  <= 1'b0;
        wait_for(2, h, "bvalid");
        resp0 = bresp[h];
        id0   = bid[h];
        repeat (hold) begin
            @(negedge clk);
            check_value({name, " bvalid held"}, 32'd1, 32'(bvalid[h]));
            check_value({name, " bresp held"}, 32'(resp0), 32'(bresp[h]));
            check_value({name, " bid held"}, 32'(id0), 32'(bid[h]));
            check_value({name, " other awready"}, 32'd0, 32'(awready[!h]));
        end
        @(posedge clk);
        bready[h] <= 1'b1;
        @(posedge clk);
        bready[h] <= 1'b0;
        check_value({name, " bresp"}, 32'((region == 2) ? resp_decerr : resp_okay), 32'(resp0));
        check_value({name, " bid"}, 32'(id), 32'(id0));
    endtask

    task automatic check_word(input string name, input int w);
        @(posedge clk);
        ram_rd_addr <= ram_addr_width'(w);
        @(negedge clk);
        check_value($sformatf("%s ram[%0d]", name, w), ram_model[w], ram_rd_data);
    endtask

    task automatic check_regs(input string name);
        @(negedge clk);
        check_value({name, " ctrl0"}, reg_model[0], ctrl0);
        check_value({name, " ctrl1"}, reg_model[1], ctrl1);
        check_value({name, " ctrl2"}, reg_model[2], ctrl2);
        check_value({name, " ctrl3"}, reg_model[3], ctrl3);
    endtask

    task automatic sweep_all(input string name);
        for (int w = 0; w < ram_words; w++) begin
            check_word(name, w);
        end
        check_regs(name);
    endtask

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////
    initial begin
        int w, beats, addr, a0, a1, hold;
        rst_n       = 1'b0;
        awvalid     = '0;
        wvalid      = '0;
        wlast       = '0;
        bready      = '0;
        ram_rd_addr = '0;
        for (int h = 0; h < 2; h++) begin
            awaddr[h]  = '0;
            awlen[h]   = '0;
            awsize[h]  = 3'd2;
            awburst[h] = burst_incr;
            awid[h]    = '0;
            wdata[h]   = '0;
            wstrb[h]   = '0;
            reg_model[h]     = '0;
            reg_model[h + 2] = '0;
        end
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        // Known RAM contents, 8 words per burst
        for (int b = 0; b < ram_words / 8; b++) begin
            write_burst("fill", 1'b0, 16'(b * 32), 8, 0, 1'b1);
        end
        sweep_all("fill");

        for (int n = 0; n < 20; n++) begin
            w = rand_range(0, ram_words - 1);
            write_burst("single", 1'b0, 16'(w * 4), 1, rand_range(0, 2), 1'b0);
            check_word("single", w);
        end

        // Bursts stay inside the RAM so neighbors can be swept
        for (int n = 0; n < 12; n++) begin
            beats = rand_range(1, 8);
            w = rand_range(0, ram_words - beats);
            write_burst("burst", 1'(rand_range(0, 1)), 16'(w * 4), beats, 0, 1'b0);
            sweep_all("burst");
        end

        for (int n = 0; n < 12; n++) begin
            addr = int'(reg_base) + 4 * rand_range(0, 3);
            write_burst("regs", 1'(rand_range(0, 1)), 16'(addr), rand_range(1, 4), 0, 1'b0);
            check_regs("regs");
        end

        // Misses below and above the register window
        for (int n = 0; n < 12; n++) begin
            if (n % 2 == 0) begin
                addr = rand_range(int'(ram_end), int'(reg_base) - 1);
            end else begin
                addr = rand_range(int'(reg_end), 65535);
            end
            write_burst("decerr", 1'(rand_range(0, 1)), 16'(addr), rand_range(1, 8), 0, 1'b0);
        end
        sweep_all("decerr");

        // CPU in the low half, DMA in the high half
        for (int n = 0; n < 8; n++) begin
            a0 = rand_range(0, 120);
            a1 = rand_range(128, 248);
            fork
                write_burst("dual cpu", 1'b0, 16'(4 * a0), rand_range(1, 8), 0, 1'b0);
                write_burst("dual dma", 1'b1, 16'(4 * a1), rand_range(1, 8), 0, 1'b0);
            join
        end
        sweep_all("dual");

        // DMA requests while the CPU holds off its B
        for (int n = 0; n < 6; n++) begin
            a0 = rand_range(0, 120);
            a1 = rand_range(128, 248);
            hold = rand_range(3, 16);
            fork
                write_burst("hold cpu", 1'b0, 16'(4 * a0), 4, hold, 1'b0);
                begin
                    repeat (2) @(posedge clk);
                    write_burst("hold dma", 1'b1, 16'(4 * a1), 2, 0, 1'b0);
                end
            join
        end
        sweep_all("hold");

        $display("All tests passed");
        $finish;
    end

endmodule

// File: hw/axi_wr_top.sv
// Top level of the AXI write interconnect. The CPU and DMA hosts share one
// write path into the on-chip RAM and the control register block.
module axi_wr_top
    import axi_wr_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    // CPU host
    input  logic                      cpu_awvalid, cpu_wvalid, cpu_wlast, cpu_bready,
    output logic                      cpu_awready, cpu_wready, cpu_bvalid,
    input  logic [addr_width-1:0]     cpu_awaddr,
    input  logic [7:0]                cpu_awlen,
    input  logic [2:0]                cpu_awsize,
    input  logic [1:0]                cpu_awburst,
    input  logic [id_width-1:0]       cpu_awid,
    input  logic [data_width-1:0]     cpu_wdata,
    input  logic [strb_width-1:0]     cpu_wstrb,
    output logic [1:0]                cpu_bresp,
    output logic [id_width-1:0]       cpu_bid,
    // DMA host
    input  logic                      dma_awvalid, dma_wvalid, dma_wlast, dma_bready,
    output logic                      dma_awready, dma_wready, dma_bvalid,
    input  logic [addr_width-1:0]     dma_awaddr,
    input  logic [7:0]                dma_awlen,
    input  logic [2:0]                dma_awsize,
    input  logic [1:0]                dma_awburst,
    input  logic [id_width-1:0]       dma_awid,
    input  logic [data_width-1:0]     dma_wdata,
    input  logic [strb_width-1:0]     dma_wstrb,
    output logic [1:0]                dma_bresp,
    output logic [id_width-1:0]       dma_bid,
    // RAM read port and control outputs
    input  logic [ram_addr_width-1:0] ram_rd_addr,
    output logic [data_width-1:0]     ram_rd_data,
    output logic [data_width-1:0]     ctrl0, ctrl1, ctrl2, ctrl3
);

    // Upstream bus
    logic up_awvalid, up_awready, up_wvalid, up_wready, up_wlast, up_bvalid, up_bready;
    logic [addr_width-1:0]  up_awaddr, dn_awaddr;
    logic [7:0]             up_awlen, dn_awlen;
    logic [2:0]             up_awsize;
    logic [1:0]             up_awburst, up_bresp, ram_bresp, regs_bresp;
    logic [id_width-1:0]    up_awid, up_bid, dn_awid, ram_bid, regs_bid;
    logic [data_width-1:0]  up_wdata, dn_wdata;
    logic [strb_width-1:0]  up_wstrb, dn_wstrb;
    logic                   dn_wlast;
    // Per-client handshakes
    logic [num_clients-1:0] dn_awvalid, dn_awready, dn_wvalid, dn_wready, dn_bvalid, dn_bready;

    axi_wr_arbiter i_arbiter (.*);

    // Both clients assume word-sized INCR bursts
    axi_write_router i_router (
        .dn_awsize  (),
        .dn_awburst (),
        .*
    );

    axi_wr_ram i_ram (
        .clk     (clk),                     .rst_n   (rst_n),
        .awvalid (dn_awvalid[client_ram]),  .awready (dn_awready[client_ram]),
        .awaddr  (dn_awaddr),               .awlen   (dn_awlen),
        .awid    (dn_awid),
        .wvalid  (dn_wvalid[client_ram]),   .wready  (dn_wready[client_ram]),
        .wdata   (dn_wdata),                .wstrb   (dn_wstrb),
        .wlast   (dn_wlast),
        .bvalid  (dn_bvalid[client_ram]),   .bready  (dn_bready[client_ram]),
        .bresp   (ram_bresp),               .bid     (ram_bid),
        .rd_addr (ram_rd_addr),             .rd_data (ram_rd_data)
    );

    axi_wr_regs i_regs (
        .clk     (clk),                     .rst_n   (rst_n),
        .awvalid (dn_awvalid[client_regs]), .awready (dn_awready[client_regs]),
        .awaddr  (dn_awaddr),               .awlen   (dn_awlen),
        .awid    (dn_awid),
        .wvalid  (dn_wvalid[client_regs]),  .wready  (dn_wready[client_regs]),
        .wdata   (dn_wdata),                .wstrb   (dn_wstrb),
        .wlast   (dn_wlast),
        .bvalid  (dn_bvalid[client_regs]),  .bready  (dn_bready[client_regs]),
        .bresp   (regs_bresp),              .bid     (regs_bid),
        .ctrl0   (ctrl0),                   .ctrl1   (ctrl1),
        .ctrl2   (ctrl2),                   .ctrl3   (ctrl3)
    );

endmodule

// File: hw/axi_wr_regs.sv
// Four 32-bit control registers written over AXI bursts with strobes.
// The register contents leave the block as the ctrl outputs.
module axi_wr_regs
    import axi_wr_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  awvalid,
    output logic                  awready,
    input  logic [addr_width-1:0] awaddr,
    input  logic [7:0]            awlen,
    input  logic [id_width-1:0]   awid,
    input  logic                  wvalid,
    output logic                  wready,
    input  logic [data_width-1:0] wdata,
    input  logic [strb_width-1:0] wstrb,
    input  logic                  wlast,
    output logic                  bvalid,
    input  logic                  bready,
    output logic [1:0]            bresp,
    output logic [id_width-1:0]   bid,
    output logic [data_width-1:0] ctrl0, ctrl1, ctrl2, ctrl3
);

    logic [data_width-1:0]     regs_q [reg_count];
    logic                      w_phase;
    logic [reg_addr_width-1:0] word_addr;
    logic [7:0]                beats_left;
    logic                      w_fire;
    logic                      w_end;

    assign awready = !w_phase && !bvalid;
    assign wready  = w_phase;
    assign bresp   = resp_okay;
    assign w_fire  = wvalid && wready;
    assign w_end   = wlast || (beats_left == 8'd0);

    assign ctrl0 = regs_q[0];
    assign ctrl1 = regs_q[1];
    assign ctrl2 = regs_q[2];
    assign ctrl3 = regs_q[3];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            w_phase <= 1'b0;
            bvalid  <= 1'b0;
        end else if (awvalid && awready) begin
            w_phase <= 1'b1;
        end else if (w_fire && w_end) begin
            w_phase <= 1'b0;
            bvalid  <= 1'b1;
        end else if (bvalid && bready) begin
            bvalid <= 1'b0;
        end
    end

    // Word offset wraps within the four registers
    always_ff @(posedge clk) begin
        if (awvalid && awready) begin
            word_addr  <= awaddr[reg_addr_width+1:2];
            beats_left <= awlen;
            bid        <= awid;
        end else if (w_fire) begin
            word_addr  <= word_addr + 1'b1;
            beats_left <= beats_left - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int r = 0; r < reg_count; r++) begin
                regs_q[r] <= '0;
            end
        end else if (w_fire) begin
            for (int b = 0; b < strb_width; b++) begin
                if (wstrb[b]) begin
                    regs_q[word_addr][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

// File: hw/axi_wr_ram.sv
// On-chip RAM on the write router. Takes one INCR write burst at a time with
// byte strobes and has a combinational read port for a local consumer.
module axi_wr_ram
    import axi_wr_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      awvalid,
    output logic                      awready,
    input  logic [addr_width-1:0]     awaddr,
    input  logic [7:0]                awlen,
    input  logic [id_width-1:0]       awid,
    input  logic                      wvalid,
    output logic                      wready,
    input  logic [data_width-1:0]     wdata,
    input  logic [strb_width-1:0]     wstrb,
    input  logic                      wlast,
    output logic                      bvalid,
    input  logic                      bready,
    output logic [1:0]                bresp,
    output logic [id_width-1:0]       bid,
    input  logic [ram_addr_width-1:0] rd_addr,
    output logic [data_width-1:0]     rd_data
);

    logic [data_width-1:0]     mem [ram_words];
    logic                      w_phase;
    logic [ram_addr_width-1:0] word_addr;
    logic [7:0]                beats_left;
    logic                      w_fire;
    logic                      w_end;

    assign awready = !w_phase && !bvalid;
    assign wready  = w_phase;
    assign bresp   = resp_okay;
    assign w_fire  = wvalid && wready;
    // Burst ends on wlast or when the AW length runs out
    assign w_end   = wlast || (beats_left == 8'd0);
    assign rd_data = mem[rd_addr];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            w_phase <= 1'b0;
            bvalid  <= 1'b0;
        end else if (awvalid && awready) begin
            w_phase <= 1'b1;
        end else if (w_fire && w_end) begin
            w_phase <= 1'b0;
            bvalid  <= 1'b1;
        end else if (bvalid && bready) begin
            bvalid <= 1'b0;
        end
    end

    // Burst word address, remaining length and ID
    always_ff @(posedge clk) begin
        if (awvalid && awready) begin
            word_addr  <= awaddr[ram_addr_width+1:2];
            beats_left <= awlen;
            bid        <= awid;
        end else if (w_fire) begin
            word_addr  <= word_addr + 1'b1;
            beats_left <= beats_left - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (w_fire) begin
            for (int b = 0; b < strb_width; b++) begin
                if (wstrb[b]) begin
                    mem[word_addr][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

// File: axi_write_router/axi_write_router.sv
// 1-to-2 AXI write router. Decodes each AW address against the region map,
// rebases it for the RAM or the register block and answers misses with DECERR.
module axi_write_router
    import axi_wr_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    // Upstream slave port
    input  logic                   up_awvalid, up_wvalid, up_wlast, up_bready,
    output logic                   up_awready, up_wready, up_bvalid,
    input  logic [addr_width-1:0]  up_awaddr,
    input  logic [7:0]             up_awlen,
    input  logic [2:0]             up_awsize,
    input  logic [1:0]             up_awburst,
    input  logic [id_width-1:0]    up_awid,
    input  logic [data_width-1:0]  up_wdata,
    input  logic [strb_width-1:0]  up_wstrb,
    output logic [1:0]             up_bresp,
    output logic [id_width-1:0]    up_bid,
    // Client ports, handshakes per client and payload shared
    output logic [num_clients-1:0] dn_awvalid, dn_wvalid, dn_bready,
    input  logic [num_clients-1:0] dn_awready, dn_wready, dn_bvalid,
    output logic [addr_width-1:0]  dn_awaddr,
    output logic [7:0]             dn_awlen,
    output logic [2:0]             dn_awsize,
    output logic [1:0]             dn_awburst,
    output logic [id_width-1:0]    dn_awid,
    output logic [data_width-1:0]  dn_wdata,
    output logic [strb_width-1:0]  dn_wstrb,
    output logic                   dn_wlast,
    input  logic [1:0]             ram_bresp, regs_bresp,
    input  logic [id_width-1:0]    ram_bid, regs_bid
);

    logic [1:0]            state;
    logic                  sel;
    logic                  aw_done;
    logic                  w_done;
    logic [addr_width-1:0] addr_q;
    logic [id_width-1:0]   id_q;
    logic                  hit_ram;
    logic                  hit_regs;

    function automatic logic in_region(input logic [addr_width-1:0] a,
                                       input logic [addr_width-1:0] lo,
                                       input logic [addr_width-1:0] hi);
        return (a >= lo) && (a < hi);
    endfunction

    assign hit_ram  = in_region(up_awaddr, ram_base, ram_end);
    assign hit_regs = in_region(up_awaddr, reg_base, reg_end);

    // Address is the rebased copy, the rest passes straight through
    assign dn_awaddr  = addr_q;
    assign dn_awlen   = up_awlen;
    assign dn_awsize  = up_awsize;
    assign dn_awburst = up_awburst;
    assign dn_awid    = up_awid;
    assign dn_wdata   = up_wdata;
    assign dn_wstrb   = up_wstrb;
    assign dn_wlast   = up_wlast;

    ////////////////////////////////////////
    // Handshake steering
    ////////////////////////////////////////
    always_comb begin
        up_awready = 1'b0;
        up_wready  = 1'b0;
        up_bvalid  = 1'b0;
        up_bresp   = (sel == client_regs) ? regs_bresp : ram_bresp;
        up_bid     = (sel == client_regs) ? regs_bid : ram_bid;
        dn_awvalid = '0;
        dn_wvalid  = '0;
        dn_bready  = '0;
        case (state)
            rt_idle: begin
                // Misses are taken here, hits wait for ACTIVE
                up_awready = up_awvalid && !hit_ram && !hit_regs;
            end
            rt_active: begin
                dn_awvalid[sel] = up_awvalid && !aw_done;
                up_awready      = dn_awready[sel] && !aw_done;
                dn_wvalid[sel]  = up_wvalid && !w_done;
                up_wready       = dn_wready[sel] && !w_done;
                if (aw_done && w_done) begin
                    up_bvalid      = dn_bvalid[sel];
                    dn_bready[sel] = up_bready;
                end
            end
            rt_decerr: begin
                // Swallow the W beats, then answer
                up_wready = !w_done;
                up_bvalid = w_done;
                up_bresp  = resp_decerr;
                up_bid    = id_q;
            end
            default: begin
                up_bvalid = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= rt_idle;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end else begin
            if (state == rt_idle && up_awvalid) begin
                state <= (hit_ram || hit_regs) ? rt_active : rt_decerr;
            end
            if (state == rt_active && up_awvalid && up_awready) begin
                aw_done <= 1'b1;
            end
            if (state != rt_idle && up_wvalid && up_wready && up_wlast) begin
                w_done <= 1'b1;
            end
            if (up_bvalid && up_bready) begin
                state   <= rt_idle;
                aw_done <= 1'b0;
                w_done  <= 1'b0;
            end
        end
    end

    // Decode results held for the rest of the transaction
    always_ff @(posedge clk) begin
        if (state == rt_idle && up_awvalid) begin
            sel    <= hit_regs ? client_regs : client_ram;
            addr_q <= hit_regs ? up_awaddr - reg_base : up_awaddr - ram_base;
            id_q   <= up_awid;
        end
    end

endmodule

// File: hw/axi_wr_arbiter.sv
// Round-robin arbiter between the CPU and DMA write hosts. The winner owns
// the upstream write bus for a whole transaction, from AW to the B handshake.
module axi_wr_arbiter
    import axi_wr_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    // CPU host
    input  logic                  cpu_awvalid, cpu_wvalid, cpu_wlast, cpu_bready,
    output logic                  cpu_awready, cpu_wready, cpu_bvalid,
    input  logic [addr_width-1:0] cpu_awaddr,
    input  logic [7:0]            cpu_awlen,
    input  logic [2:0]            cpu_awsize,
    input  logic [1:0]            cpu_awburst,
    input  logic [id_width-1:0]   cpu_awid,
    input  logic [data_width-1:0] cpu_wdata,
    input  logic [strb_width-1:0] cpu_wstrb,
    output logic [1:0]            cpu_bresp,
    output logic [id_width-1:0]   cpu_bid,
    // DMA host
    input  logic                  dma_awvalid, dma_wvalid, dma_wlast, dma_bready,
    output logic                  dma_awready, dma_wready, dma_bvalid,
    input  logic [addr_width-1:0] dma_awaddr,
    input  logic [7:0]            dma_awlen,
    input  logic [2:0]            dma_awsize,
    input  logic [1:0]            dma_awburst,
    input  logic [id_width-1:0]   dma_awid,
    input  logic [data_width-1:0] dma_wdata,
    input  logic [strb_width-1:0] dma_wstrb,
    output logic [1:0]            dma_bresp,
    output logic [id_width-1:0]   dma_bid,
    // Upstream bus toward the router
    output logic                  up_awvalid, up_wvalid, up_wlast, up_bready,
    input  logic                  up_awready, up_wready, up_bvalid,
    output logic [addr_width-1:0] up_awaddr,
    output logic [7:0]            up_awlen,
    output logic [2:0]            up_awsize,
    output logic [1:0]            up_awburst,
    output logic [id_width-1:0]   up_awid,
    output logic [data_width-1:0] up_wdata,
    output logic [strb_width-1:0] up_wstrb,
    input  logic [1:0]            up_bresp,
    input  logic [id_width-1:0]   up_bid
);

    logic [num_hosts-1:0] req;
    logic                 busy;
    logic                 grant;
    logic                 last_winner;
    logic                 winner;

    assign req = {dma_awvalid, cpu_awvalid};

    // Both requesting means the host after the last winner goes first
    assign winner = (&req) ? !last_winner : req[1];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy        <= 1'b0;
            grant       <= 1'b0;
            last_winner <= 1'b1;
        end else if (!busy) begin
            if (|req) begin
                busy  <= 1'b1;
                grant <= winner;
            end
        end else if (up_bvalid && up_bready) begin
            busy        <= 1'b0;
            last_winner <= grant;
        end
    end

    ////////////////////////////////////////
    // Host to upstream mux
    ////////////////////////////////////////
    assign up_awvalid = busy && (grant ? dma_awvalid : cpu_awvalid);
    assign up_awaddr  = grant ? dma_awaddr : cpu_awaddr;
    assign up_awlen   = grant ? dma_awlen : cpu_awlen;
    assign up_awsize  = grant ? dma_awsize : cpu_awsize;
    assign up_awburst = grant ? dma_awburst : cpu_awburst;
    assign up_awid    = grant ? dma_awid : cpu_awid;
    assign up_wvalid  = busy && (grant ? dma_wvalid : cpu_wvalid);
    assign up_wdata   = grant ? dma_wdata : cpu_wdata;
    assign up_wstrb   = grant ? dma_wstrb : cpu_wstrb;
    assign up_wlast   = grant ? dma_wlast : cpu_wlast;
    assign up_bready  = busy && (grant ? dma_bready : cpu_bready);

    // Ready and B go back to the granted host only
    assign cpu_awready = busy && !grant && up_awready;
    assign cpu_wready  = busy && !grant && up_wready;
    assign cpu_bvalid  = busy && !grant && up_bvalid;
    assign dma_awready = busy && grant && up_awready;
    assign dma_wready  = busy && grant && up_wready;
    assign dma_bvalid  = busy && grant && up_bvalid;
    assign cpu_bresp   = up_bresp;
    assign cpu_bid     = up_bid;
    assign dma_bresp   = up_bresp;
    assign dma_bid     = up_bid;

endmodule

// File: common/axi_wr_pkg.sv
// Shared widths, response and burst codes and the address map of the AXI
// write interconnect. Every module takes it with a wildcard import.
package axi_wr_pkg;

    // Bus widths
    localparam int addr_width = 16;
    localparam int data_width = 32;
    localparam int strb_width = data_width / 8;
    localparam int id_width   = 4;

    // B response codes
    localparam logic [1:0] resp_okay   = 2'd0;
    localparam logic [1:0] resp_slverr = 2'd2;
    localparam logic [1:0] resp_decerr = 2'd3;

    localparam logic [1:0] burst_incr = 2'd1;

    // Client storage
    localparam int ram_words      = 256;
    localparam int ram_addr_width = $clog2(ram_words);
    localparam int reg_count      = 4;
    localparam int reg_addr_width = $clog2(reg_count);

    ////////////////////////////////////////
    // Region map with exclusive end addresses
    ////////////////////////////////////////
    localparam logic [addr_width-1:0] ram_base = 16'h0000;
    localparam logic [addr_width-1:0] ram_end  = 16'h0400;
    localparam logic [addr_width-1:0] reg_base = 16'h1000;
    localparam logic [addr_width-1:0] reg_end  = 16'h1010;

    // Router client indices
    localparam logic client_ram  = 1'b0;
    localparam logic client_regs = 1'b1;
    localparam int   num_clients = 2;

    localparam int num_hosts = 2;

    // Router FSM states
    localparam logic [1:0] rt_idle   = 2'd0;
    localparam logic [1:0] rt_active = 2'd1;
    localparam logic [1:0] rt_decerr = 2'd2;

endpackage
